/* fb_defs.svh */
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// ----------------------------------------
// raster geometry
// ----------------------------------------
`define FB_COLS          32
`define FB_ROWS          24
`define FB_PIXELS        768
`define PIXEL_BITS       4
`define FB_ADDR_BITS     10

// ----------------------------------------
// host register map, byte offsets
// ----------------------------------------
// the pixel window starts at offset 0, one pixel per 32-bit word
`define PIX_WINDOW_BYTES 13'h0C00
`define REG_CTRL_OFS     13'h1000
`define REG_STATUS_OFS   13'h1004

`endif

/* fb_pkg.sv */
`include "fb_defs.svh"

package fb_pkg;

  typedef logic [`PIXEL_BITS-1:0]   pixel_t;
  typedef logic [`FB_ADDR_BITS-1:0] pix_addr_t;

  // pixel view of a bus word, upper bits ignored on write and zero on read
  typedef struct packed {
    logic [31-`PIXEL_BITS:0] unused;
    pixel_t                  pix;
  } pix_view_t;

  // control view of a bus word
  typedef struct packed {
    logic [30:0] unused;
    logic        swap;
  } ctrl_view_t;

  typedef union packed {
    pix_view_t  pix;
    ctrl_view_t ctrl;
  } fb_word_u;

  // front_sel sits in bit 0, swap_pending in bit 1, the counter in bits 17:2
  typedef struct packed {
    logic [13:0] pad;
    logic [15:0] frame_count;
    logic        swap_pending;
    logic        front_sel;
  } status_t;

endpackage

/* axil_pkg.sv */
package axil_pkg;

  // 13 bits cover the pixel window and the two registers above it
  typedef logic [12:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // only the two codes this slave can return
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

endpackage

/* dp_ram.sv */
`timescale 1ns/10ps
`include "fb_defs.svh"

module dp_ram #(
  parameter int DATA_BITS = `PIXEL_BITS,
  parameter int DEPTH     = `FB_PIXELS
) (
  input  logic                     clk,
  // port A reads and writes
  input  logic                     a_en,
  input  logic                     a_we,
  input  logic [$clog2(DEPTH)-1:0] a_addr,
  input  logic [DATA_BITS-1:0]     a_din,
  output logic [DATA_BITS-1:0]     a_dout,
  // port B only reads
  input  logic                     b_en,
  input  logic [$clog2(DEPTH)-1:0] b_addr,
  output logic [DATA_BITS-1:0]     b_dout
);

  // contents start cleared, as an initialised block RAM does
  logic [DATA_BITS-1:0] mem [DEPTH] = '{default: '0};
  logic [DATA_BITS-1:0] a_q;
  logic [DATA_BITS-1:0] b_q;

  // read-first, so a write on port A returns the old word
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_q <= mem[a_addr];
      if (a_we) begin
        mem[a_addr] <= a_din;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      b_q <= mem[b_addr];
    end
  end

  // output registers give the second cycle of latency
  always_ff @(posedge clk) begin
    a_dout <= a_q;
    b_dout <= b_q;
  end

endmodule

/* double_buffer.sv */
`timescale 1ns/10ps
`include "fb_defs.svh"

module double_buffer (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en,
  input  fb_pkg::pix_addr_t wr_addr,
  input  fb_pkg::pixel_t    wr_data,
  input  logic              bk_rd_en,
  input  fb_pkg::pix_addr_t bk_rd_addr,
  output fb_pkg::pixel_t    bk_rd_data,
  input  fb_pkg::pix_addr_t scan_addr,
  output fb_pkg::pixel_t    scan_data,
  input  logic              swap_req,
  input  logic              frame_boundary,
  output logic              front_sel,
  output logic              swap_pending
);
  import fb_pkg::*;

  logic      front_next;
  logic      host_en;
  pix_addr_t host_addr;
  pixel_t    host_dout [2];
  pixel_t    scan_dout [2];
  logic      bk_sel_d1;
  logic      bk_sel_d2;
  logic      scan_sel_d2;

  // ----------------------------------------
  // bank select and pending swap
  // ----------------------------------------
  // the swap lands on the cycle that address 0 is issued
  assign front_next = front_sel ^ (frame_boundary & swap_pending);

  always_ff @(posedge clk) begin
    if (rst) begin
      front_sel    <= 1'b0;
      swap_pending <= 1'b0;
      bk_sel_d1    <= 1'b1;
      bk_sel_d2    <= 1'b1;
      scan_sel_d2  <= 1'b0;
    end else begin
      front_sel    <= front_next;
      swap_pending <= swap_req | (swap_pending & ~frame_boundary);
      bk_sel_d1    <= ~front_next;
      bk_sel_d2    <= bk_sel_d1;
      // front_sel already holds the select one cycle after the address
      scan_sel_d2  <= front_sel;
    end
  end

  // ----------------------------------------
  // banks, port A host and port B scan
  // ----------------------------------------
  // the slave never writes and reads in the same cycle
  assign host_en   = wr_en | bk_rd_en;
  assign host_addr = wr_en ? wr_addr : bk_rd_addr;

  dp_ram #(.DATA_BITS(`PIXEL_BITS), .DEPTH(`FB_PIXELS)) bank0 (
    .clk    (clk),
    .a_en   (host_en),
    .a_we   (wr_en & front_next),
    .a_addr (host_addr),
    .a_din  (wr_data),
    .a_dout (host_dout[0]),
    .b_en   (1'b1),
    .b_addr (scan_addr),
    .b_dout (scan_dout[0])
  );

  dp_ram #(.DATA_BITS(`PIXEL_BITS), .DEPTH(`FB_PIXELS)) bank1 (
    .clk    (clk),
    .a_en   (host_en),
    .a_we   (wr_en & ~front_next),
    .a_addr (host_addr),
    .a_din  (wr_data),
    .a_dout (host_dout[1]),
    .b_en   (1'b1),
    .b_addr (scan_addr),
    .b_dout (scan_dout[1])
  );

  assign bk_rd_data = host_dout[bk_sel_d2];
  assign scan_data  = scan_dout[scan_sel_d2];

endmodule

/* axil_fb_slave.sv */
`timescale 1ns/10ps
`include "fb_defs.svh"

module axil_fb_slave (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 awvalid,
  output logic                 awready,
  input  axil_pkg::axil_addr_t awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  axil_pkg::axil_data_t wdata,
  output logic                 bvalid,
  input  logic                 bready,
  output axil_pkg::axil_resp_t bresp,
  input  logic                 arvalid,
  output logic                 arready,
  input  axil_pkg::axil_addr_t araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output axil_pkg::axil_data_t rdata,
  output axil_pkg::axil_resp_t rresp,
  output logic                 wr_en,
  output fb_pkg::pix_addr_t    wr_addr,
  output fb_pkg::pixel_t       wr_data,
  output logic                 bk_rd_en,
  output fb_pkg::pix_addr_t    bk_rd_addr,
  input  fb_pkg::pixel_t       bk_rd_data,
  output logic                 swap_req,
  input  logic                 front_sel,
  input  logic                 swap_pending,
  input  logic                 frame_tick
);
  import fb_pkg::*;
  import axil_pkg::*;

  typedef enum logic [1:0] {REG_PIX, REG_CTRL, REG_STATUS, REG_ERR} region_e;

  typedef enum logic [2:0] {
    S_INIT, S_IDLE, S_WRESP, S_RWAIT1, S_RWAIT2, S_RRESP
  } state_e;

  state_e      state;
  region_e     wr_region;
  region_e     rd_region;
  logic        wr_accept;
  logic        rd_accept;
  fb_word_u    wr_word;
  fb_word_u    reg_word;
  fb_word_u    pix_word;
  status_t     status;
  logic [15:0] frame_count;

  function automatic region_e decode(axil_addr_t addr);
    region_e r;
    if (addr < `PIX_WINDOW_BYTES) r = REG_PIX;
    else if (addr == `REG_CTRL_OFS) r = REG_CTRL;
    else if (addr == `REG_STATUS_OFS) r = REG_STATUS;
    else r = REG_ERR;
    return r;
  endfunction

  // ----------------------------------------
  // handshakes and decode
  // ----------------------------------------
  assign awready = (state == S_IDLE);
  assign wready  = (state == S_IDLE);
  // a write takes priority when both kinds arrive together
  assign arready = (state == S_IDLE) && !(awvalid && wvalid);
  assign bvalid  = (state == S_WRESP);
  assign rvalid  = (state == S_RRESP);

  assign wr_accept = awvalid && wvalid && awready;
  assign rd_accept = arvalid && arready;
  assign wr_region = decode(awaddr);
  assign rd_region = decode(araddr);
  assign wr_word   = wdata;

  // pixel index is the word index inside the window
  assign wr_en      = wr_accept && (wr_region == REG_PIX);
  assign wr_addr    = awaddr[`FB_ADDR_BITS+1:2];
  assign wr_data    = wr_word.pix.pix;
  assign swap_req   = wr_accept && (wr_region == REG_CTRL) && wr_word.ctrl.swap;
  assign bk_rd_en   = rd_accept && (rd_region == REG_PIX);
  assign bk_rd_addr = araddr[`FB_ADDR_BITS+1:2];

  // ----------------------------------------
  // read data words
  // ----------------------------------------
  assign status = '{pad: '0, frame_count: frame_count,
                    swap_pending: swap_pending, front_sel: front_sel};

  always_comb begin
    reg_word = '0;
    if (rd_region == REG_STATUS) begin
      reg_word = status;
    end else if (rd_region == REG_CTRL) begin
      // the swap bit reads back as set until the swap has happened
      reg_word.ctrl.swap = swap_pending;
    end
  end

  always_comb begin
    pix_word         = '0;
    pix_word.pix.pix = bk_rd_data;
  end

  // ----------------------------------------
  // FSM and frame counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_INIT;
      frame_count <= '0;
    end else begin
      if (frame_tick) frame_count <= frame_count + 16'd1;
      case (state)
        S_INIT:   state <= S_IDLE;
        S_IDLE: begin
          if (wr_accept) state <= S_WRESP;
          else if (rd_accept) state <= (rd_region == REG_PIX) ? S_RWAIT1 : S_RRESP;
        end
        S_WRESP:  if (bready) state <= S_IDLE;
        S_RWAIT1: state <= S_RWAIT2;
        S_RWAIT2: state <= S_RRESP;
        S_RRESP:  if (rready) state <= S_IDLE;
        default:  state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp <= (wr_region == REG_ERR) ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_accept) begin
      rresp <= (rd_region == REG_ERR) ? RESP_SLVERR : RESP_OKAY;
      rdata <= reg_word;
    end
    // the RAM word arrives two cycles after the request
    if (state == S_RWAIT2) begin
      rdata <= pix_word;
    end
  end

endmodule

/* scan_out.sv */
`timescale 1ns/10ps
`include "fb_defs.svh"

module scan_out (
  input  logic              clk,
  input  logic              rst,
  output fb_pkg::pix_addr_t scan_addr,
  output logic              frame_boundary,
  output logic              frame_tick,
  input  fb_pkg::pixel_t    scan_data,
  output logic              pix_valid,
  output fb_pkg::pixel_t    pix_data,
  output logic              line_start,
  output logic              frame_start
);
  import fb_pkg::*;

  logic [$clog2(`FB_COLS)-1:0] col;
  logic [$clog2(`FB_ROWS)-1:0] row;
  logic                        last_col;
  logic                        last_row;
  logic                        valid_d1;
  logic                        line_d1;
  logic                        frame_d1;

  // ----------------------------------------
  // raster counters, one address per cycle
  // ----------------------------------------
  assign last_col = (col == `FB_COLS - 1);
  assign last_row = (row == `FB_ROWS - 1);

  assign scan_addr      = pix_addr_t'(row) * pix_addr_t'(`FB_COLS) + pix_addr_t'(col);
  assign frame_boundary = (col == '0) && (row == '0);
  assign frame_tick     = last_col && last_row;

  always_ff @(posedge clk) begin
    if (rst) begin
      col <= '0;
      row <= '0;
    end else if (last_col) begin
      col <= '0;
      row <= last_row ? '0 : row + 1'b1;
    end else begin
      col <= col + 1'b1;
    end
  end

  // markers travel two stages to meet the RAM data
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_d1    <= 1'b0;
      line_d1     <= 1'b0;
      frame_d1    <= 1'b0;
      pix_valid   <= 1'b0;
      line_start  <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      valid_d1    <= 1'b1;
      line_d1     <= (col == '0);
      frame_d1    <= frame_boundary;
      pix_valid   <= valid_d1;
      line_start  <= line_d1;
      frame_start <= frame_d1;
    end
  end

  assign pix_data = scan_data;

endmodule

/* fb_top.sv */
`timescale 1ns/10ps
`include "fb_defs.svh"

module fb_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 awvalid,
  output logic                 awready,
  input  axil_pkg::axil_addr_t awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  axil_pkg::axil_data_t wdata,
  output logic                 bvalid,
  input  logic                 bready,
  output axil_pkg::axil_resp_t bresp,
  input  logic                 arvalid,
  output logic                 arready,
  input  axil_pkg::axil_addr_t araddr,
  output logic                 rvalid,
  input  logic                 rready,
  output axil_pkg::axil_data_t rdata,
  output axil_pkg::axil_resp_t rresp,
  output logic                 pix_valid,
  output fb_pkg::pixel_t       pix_data,
  output logic                 line_start,
  output logic                 frame_start
);
  import fb_pkg::*;

  logic      wr_en;
  pix_addr_t wr_addr;
  pixel_t    wr_data;
  logic      bk_rd_en;
  pix_addr_t bk_rd_addr;
  pixel_t    bk_rd_data;
  logic      swap_req;
  logic      front_sel;
  logic      swap_pending;
  pix_addr_t scan_addr;
  pixel_t    scan_data;
  logic      frame_boundary;
  logic      frame_tick;

  axil_fb_slave u_slave (
    .clk, .rst,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp,
    .wr_en, .wr_addr, .wr_data,
    .bk_rd_en, .bk_rd_addr, .bk_rd_data,
    .swap_req, .front_sel, .swap_pending, .frame_tick
  );

  double_buffer u_buf (
    .clk, .rst,
    .wr_en, .wr_addr, .wr_data,
    .bk_rd_en, .bk_rd_addr, .bk_rd_data,
    .scan_addr, .scan_data,
    .swap_req, .frame_boundary,
    .front_sel, .swap_pending
  );

  scan_out u_scan (
    .clk, .rst,
    .scan_addr, .frame_boundary, .frame_tick,
    .scan_data,
    .pix_valid, .pix_data, .line_start, .frame_start
  );

endmodule

/* tb_fb_top.sv */
`timescale 1ns/10ps
`include "fb_defs.svh"

module tb_fb_top;
  import fb_pkg::*;
  import axil_pkg::*;

  // 8 frames of scan plus 4 cycles for each bus operation
  localparam int BUS_OPS        = 1600;
  localparam int TIMEOUT_CYCLES = 8 * `FB_PIXELS + 4 * BUS_OPS;

  logic       clk = 1'b0;
  logic       rst;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  axil_data_t wdata;
  logic       bvalid;
  logic       bready;
  axil_resp_t bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       pix_valid;
  pixel_t     pix_data;
  logic       line_start;
  logic       frame_start;

  // reference model of both banks and the select state
  pixel_t     bank0_model [`FB_PIXELS];
  pixel_t     bank1_model [`FB_PIXELS];
  logic       model_front;
  logic       model_pending;
  int         frames_seen;
  int         pix_idx;
  int         cycles = 0;
  int         checks = 0;
  int         errors = 0;
  int         tests = 0;
  int         test_errs;
  string      test_name;
  integer     seed = 32'h81829081;

  fb_top uut (
    .clk(clk), .rst(rst),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .pix_valid(pix_valid), .pix_data(pix_data),
    .line_start(line_start), .frame_start(frame_start)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic pixel_t expect_pixel(int idx);
    return model_front ? bank1_model[idx] : bank0_model[idx];
  endfunction

  function automatic pixel_t back_pixel(int idx);
    return model_front ? bank0_model[idx] : bank1_model[idx];
  endfunction

  // the counter steps once per completed frame, so the first frame_start adds nothing
  function automatic status_t expect_status();
    status_t s;
    s              = '0;
    s.front_sel    = model_front;
    s.swap_pending = model_pending;
    s.frame_count  = (frames_seen == 0) ? 16'd0 : 16'(frames_seen - 1);
    return s;
  endfunction

  // ----------------------------------------
  // compare tasks and test bookkeeping
  // ----------------------------------------
  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic finish_test();
    tests++;
    if (errors == test_errs) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, errors - test_errs);
    end
  endtask

  // ----------------------------------------
  // AXI4-Lite driver
  // ----------------------------------------
  // each task starts and ends 2 ns after a rising edge
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
    int hold;
    hold    = $unsigned($random(seed)) % 4;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(negedge clk); while (!awready || !wready);
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    do @(negedge clk); while (!bvalid);
    resp = bresp;
    repeat (hold) begin
      @(negedge clk);
      if (!bvalid || bresp !== resp) begin
        report_failure($sformatf("write response at %h dropped or changed before bready", addr));
      end
    end
    @(posedge clk);
    #2;
    bready = 1'b1;
    @(negedge clk);
    if (!bvalid || bresp !== resp) begin
      report_failure($sformatf("write response at %h dropped or changed before bready", addr));
    end
    @(posedge clk);
    #2;
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
    int hold;
    hold    = $unsigned($random(seed)) % 4;
    araddr  = addr;
    arvalid = 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    do @(negedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    repeat (hold) begin
      @(negedge clk);
      if (!rvalid || rdata !== data || rresp !== resp) begin
        report_failure($sformatf("read response at %h dropped or changed before rready", addr));
      end
    end
    @(posedge clk);
    #2;
    rready = 1'b1;
    @(negedge clk);
    if (!rvalid || rdata !== data || rresp !== resp) begin
      report_failure($sformatf("read response at %h dropped or changed before rready", addr));
    end
    @(posedge clk);
    #2;
    rready = 1'b0;
  endtask

  task automatic write_pixel(input int idx, input axil_data_t word);
    axil_resp_t resp;
    axil_write(axil_addr_t'(idx * 4), word, resp);
    check_resp($sformatf("%s write %0d", test_name, idx), RESP_OKAY, resp);
    // writes land in whichever bank is back
    if (model_front) begin
      bank0_model[idx] = word[`PIXEL_BITS-1:0];
    end else begin
      bank1_model[idx] = word[`PIXEL_BITS-1:0];
    end
  endtask

  task automatic read_back_pixel(input int idx);
    axil_data_t data;
    axil_resp_t resp;
    axil_data_t exp;
    axil_read(axil_addr_t'(idx * 4), data, resp);
    exp                    = '0;
    exp[`PIXEL_BITS-1:0]   = back_pixel(idx);
    check_resp($sformatf("%s read %0d", test_name, idx), RESP_OKAY, resp);
    check_data($sformatf("%s read %0d", test_name, idx), exp, data);
  endtask

  task automatic read_status(output status_t s);
    axil_data_t data;
    axil_resp_t resp;
    axil_read(`REG_STATUS_OFS, data, resp);
    check_resp($sformatf("%s status", test_name), RESP_OKAY, resp);
    s = data;
  endtask

  task automatic wait_frame_start();
    do @(negedge clk); while (!frame_start);
    @(posedge clk);
    #2;
  endtask

  // ----------------------------------------
  // pixel stream monitor
  // ----------------------------------------
  always @(negedge clk) begin
    if (!rst && pix_valid) begin
      if (frame_start) begin
        if (frames_seen > 0 && pix_idx != `FB_PIXELS) begin
          report_failure($sformatf("frame_start arrived after %0d pixels instead of a full frame",
                                   pix_idx));
        end
        // a pending swap is visible from pixel 0 of this frame
        if (model_pending) begin
          model_front   = ~model_front;
          model_pending = 1'b0;
        end
        pix_idx = 0;
        frames_seen++;
      end
      if (frames_seen > 0) begin
        if (pix_idx >= `FB_PIXELS) begin
          report_failure("frame_start did not arrive after a full frame of pixels");
          pix_idx = 0;
        end else begin
          check_pixel($sformatf("%s pixel %0d", test_name, pix_idx),
                      expect_pixel(pix_idx), pix_data);
          if (line_start !== (pix_idx % `FB_COLS == 0)) begin
            report_failure($sformatf("line_start is wrong at pixel %0d", pix_idx));
          end
          pix_idx++;
        end
      end
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    axil_resp_t resp;
    axil_data_t data;
    status_t    s0;
    status_t    s1;
    status_t    exp_s;
    int         idx;
    rst           = 1'b1;
    awvalid       = 1'b0;
    awaddr        = '0;
    wvalid        = 1'b0;
    wdata         = '0;
    bready        = 1'b0;
    arvalid       = 1'b0;
    araddr        = '0;
    rready        = 1'b0;
    model_front   = 1'b0;
    model_pending = 1'b0;
    frames_seen   = 0;
    pix_idx       = 0;
    test_name     = "reset";
    for (int i = 0; i < `FB_PIXELS; i++) begin
      bank0_model[i] = '0;
      bank1_model[i] = '0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test("reset_state");
    read_status(s0);
    check_status("reset_state status", expect_status(), s0);
    wait_frame_start();
    finish_test();

    start_test("fill_and_swap");
    for (int i = 0; i < `FB_PIXELS; i++) begin
      write_pixel(i, $random(seed));
    end
    // issue the swap early in a frame so it is pending at the next boundary
    wait_frame_start();
    axil_write(`REG_CTRL_OFS, 32'h1, resp);
    check_resp("fill_and_swap ctrl", RESP_OKAY, resp);
    model_pending = 1'b1;
    read_status(s0);
    check_status("fill_and_swap pending", expect_status(), s0);
    wait_frame_start();
    wait_frame_start();
    read_status(s0);
    check_status("fill_and_swap swapped", expect_status(), s0);
    finish_test();

    start_test("tear_free_writes");
    for (int i = 0; i < 128; i++) begin
      idx = $unsigned($random(seed)) % `FB_PIXELS;
      write_pixel(idx, $random(seed));
    end
    wait_frame_start();
    finish_test();

    start_test("back_readback");
    for (int i = 0; i < 32; i++) begin
      read_back_pixel($unsigned($random(seed)) % `FB_PIXELS);
    end
    finish_test();

    start_test("errors_backpressure");
    axil_write(13'h0C00, 32'h5, resp);
    check_resp("errors_backpressure write 0c00", RESP_SLVERR, resp);
    axil_write(13'h1010, 32'h1, resp);
    check_resp("errors_backpressure write 1010", RESP_SLVERR, resp);
    axil_read(13'h0C00, data, resp);
    check_resp("errors_backpressure read 0c00", RESP_SLVERR, resp);
    axil_read(13'h1010, data, resp);
    check_resp("errors_backpressure read 1010", RESP_SLVERR, resp);
    axil_write(`REG_STATUS_OFS, 32'hFFFF_FFFF, resp);
    check_resp("errors_backpressure write status", RESP_OKAY, resp);
    read_status(s0);
    check_status("errors_backpressure status", expect_status(), s0);
    read_back_pixel(0);
    // 0x1010 lands on pixel 4 if the upper address bits are dropped
    read_back_pixel(4);
    finish_test();

    start_test("frame_counter");
    read_status(s0);
    wait_frame_start();
    wait_frame_start();
    read_status(s1);
    exp_s             = s0;
    exp_s.frame_count = s0.frame_count + 16'd2;
    check_status("frame_counter delta", exp_s, s1);
    check_status("frame_counter model", expect_status(), s1);
    finish_test();

    repeat (4) @(posedge clk);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
fb_pkg.sv
axil_pkg.sv
dp_ram.sv
double_buffer.sv
axil_fb_slave.sv
scan_out.sv
fb_top.sv
tb_fb_top.sv

/* Bender.yml */
package:
  name: fb_double_buffer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fb_pkg.sv
      - axil_pkg.sv
      - dp_ram.sv
      - double_buffer.sv
      - axil_fb_slave.sv
      - scan_out.sv
      - fb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fb_top.sv
